// ==== logic/armCtrlPkg.sv ====
`default_nettype none

package armCtrlPkg;

  // ============================================================
  // Widths and fixed register numbers
  // ============================================================
  localparam int instrWidth = 32;
  localparam logic [3:0] pcRegIdx = 4'd15;   // r15 is the PC

  // ============================================================
  // Encodings
  // ============================================================
  typedef enum logic [1:0] {
    dataProc  = 2'd0,
    loadStore = 2'd1,
    branch    = 2'd2,
    noOp      = 2'd3   // anything outside the kept classes
  } instrClassE;

  // Values follow instruction bits 24:21
  typedef enum logic [3:0] {
    aluAnd = 4'h0,
    aluEor = 4'h1,
    aluSub = 4'h2,
    aluRsb = 4'h3,
    aluAdd = 4'h4,
    aluAdc = 4'h5,
    aluSbc = 4'h6,
    aluRsc = 4'h7,
    aluTst = 4'h8,
    aluTeq = 4'h9,
    aluCmp = 4'ha,
    aluCmn = 4'hb,
    aluOrr = 4'hc,
    aluMov = 4'hd,
    aluBic = 4'he,
    aluMvn = 4'hf
  } aluOpE;

  // Values follow instruction bits 31:28
  typedef enum logic [3:0] {
    condEq = 4'h0,
    condNe = 4'h1,
    condCs = 4'h2,
    condCc = 4'h3,
    condMi = 4'h4,
    condPl = 4'h5,
    condVs = 4'h6,
    condVc = 4'h7,
    condHi = 4'h8,
    condLs = 4'h9,
    condGe = 4'ha,
    condLt = 4'hb,
    condGt = 4'hc,
    condLe = 4'hd,
    condAl = 4'he,
    condNv = 4'hf
  } condE;

  // ============================================================
  // Grouped control
  // ============================================================
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Decode outputs carried into Execute
  typedef struct packed {
    logic  regWrite;
    logic  memWrite;
    logic  memtoReg;
    logic  branch;
    logic  pcSrc;
    logic  flagWrite;
    logic  aluSrc;
    logic  byteAccess;
    aluOpE aluControl;
    condE  cond;
  } decodeCtrlT;

  // Condition-gated Execute results
  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic       setFlags;
    logic [3:0] byteMask;
  } memCtrlT;

  typedef struct packed {
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
    logic setFlags;
  } wbCtrlT;

endpackage

`default_nettype wire

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
  input  logic [armCtrlPkg::instrWidth-1:0] instrD,
  output armCtrlPkg::decodeCtrlT            ctrlD,
  output logic [1:0]                        regSrcD,
  output logic [1:0]                        immSrcD
);

  armCtrlPkg::instrClassE instrClass;
  armCtrlPkg::aluOpE      dpOp;

  assign dpOp = armCtrlPkg::aluOpE'(instrD[24:21]);

  // ============================================================
  // Instruction class
  // ============================================================
  always_comb begin
    case (instrD[27:26])
      2'b00: begin
        // Register form with bits 7 and 4 set is multiply or halfword space
        if (!instrD[25] && instrD[7] && instrD[4])
          instrClass = armCtrlPkg::noOp;
        else
          instrClass = armCtrlPkg::dataProc;
      end
      2'b01: begin
        if (instrD[25] && instrD[4])   // Undefined space
          instrClass = armCtrlPkg::noOp;
        else
          instrClass = armCtrlPkg::loadStore;
      end
      2'b10:   instrClass = armCtrlPkg::branch;
      default: instrClass = armCtrlPkg::noOp;   // Coprocessor and SWI
    endcase
  end

  // ============================================================
  // Control bits per class
  // ============================================================
  always_comb begin
    ctrlD            = '0;
    ctrlD.aluControl = armCtrlPkg::aluAdd;
    ctrlD.cond       = armCtrlPkg::condE'(instrD[31:28]);
    immSrcD          = 2'd0;

    case (instrClass)
      armCtrlPkg::dataProc: begin
        ctrlD.aluControl = dpOp;
        ctrlD.flagWrite  = instrD[20];
        ctrlD.aluSrc     = instrD[25];     // Immediate operand
        // Compare and test ops only touch the flags
        ctrlD.regWrite   = !(dpOp inside {armCtrlPkg::aluTst, armCtrlPkg::aluTeq,
                                          armCtrlPkg::aluCmp, armCtrlPkg::aluCmn});
        immSrcD          = 2'd0;
      end

      armCtrlPkg::loadStore: begin
        ctrlD.aluControl = instrD[23] ? armCtrlPkg::aluAdd : armCtrlPkg::aluSub;  // U bit
        ctrlD.aluSrc     = !instrD[25];
        ctrlD.byteAccess = instrD[22];
        if (instrD[20]) begin   // Load
          ctrlD.memtoReg = 1'b1;
          ctrlD.regWrite = 1'b1;
        end else begin
          ctrlD.memWrite = 1'b1;
        end
        immSrcD          = 2'd1;
      end

      armCtrlPkg::branch: begin
        ctrlD.branch     = 1'b1;
        ctrlD.aluSrc     = 1'b1;
        ctrlD.aluControl = armCtrlPkg::aluAdd;   // PC + offset
        immSrcD          = 2'd2;
      end

      default: ;   // noOp keeps every write low
    endcase

    // Writing r15 redirects fetch just like a branch
    ctrlD.pcSrc = ctrlD.branch || (ctrlD.regWrite && instrD[15:12] == armCtrlPkg::pcRegIdx);
  end

  assign regSrcD = {ctrlD.memWrite, ctrlD.branch};

endmodule

`default_nettype wire

// ==== logic/execControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module execControl (
  input  armCtrlPkg::decodeCtrlT ctrlE,
  input  armCtrlPkg::flagsT      flagsE,       // forwarded flags
  input  armCtrlPkg::flagsT      aluFlagsE,
  input  logic [1:0]             addrLowE,
  output armCtrlPkg::memCtrlT    memCtrlE,
  output armCtrlPkg::flagsT      flagsNextE,
  output logic                   branchTakenE
);

  logic condPass;

  // ============================================================
  // Condition evaluation
  // ============================================================
  always_comb begin
    case (ctrlE.cond)
      armCtrlPkg::condEq: condPass = flagsE.z;
      armCtrlPkg::condNe: condPass = !flagsE.z;
      armCtrlPkg::condCs: condPass = flagsE.c;
      armCtrlPkg::condCc: condPass = !flagsE.c;
      armCtrlPkg::condMi: condPass = flagsE.n;
      armCtrlPkg::condPl: condPass = !flagsE.n;
      armCtrlPkg::condVs: condPass = flagsE.v;
      armCtrlPkg::condVc: condPass = !flagsE.v;
      armCtrlPkg::condHi: condPass = flagsE.c && !flagsE.z;
      armCtrlPkg::condLs: condPass = !flagsE.c || flagsE.z;
      armCtrlPkg::condGe: condPass = (flagsE.n == flagsE.v);
      armCtrlPkg::condLt: condPass = (flagsE.n != flagsE.v);
      armCtrlPkg::condGt: condPass = !flagsE.z && (flagsE.n == flagsE.v);
      armCtrlPkg::condLe: condPass = flagsE.z || (flagsE.n != flagsE.v);
      armCtrlPkg::condAl: condPass = 1'b1;
      default:            condPass = 1'b0;   // NV never executes
    endcase
  end

  // ============================================================
  // Gated writes and byte lanes
  // ============================================================
  always_comb begin
    memCtrlE.memWrite = ctrlE.memWrite && condPass;
    memCtrlE.memtoReg = ctrlE.memtoReg;             // only selects the result source
    memCtrlE.regWrite = ctrlE.regWrite && condPass;
    memCtrlE.pcSrc    = ctrlE.pcSrc && condPass;
    memCtrlE.setFlags = ctrlE.flagWrite && condPass;

    // Byte access enables one lane, word access all four
    if (ctrlE.byteAccess)
      memCtrlE.byteMask = 4'b0001 << addrLowE;
    else
      memCtrlE.byteMask = 4'b1111;
  end

  // New flags only when this instruction actually sets them
  assign flagsNextE   = memCtrlE.setFlags ? aluFlagsE : flagsE;
  assign branchTakenE = ctrlE.branch && condPass;

endmodule

`default_nettype wire

// ==== logic/ctrlPipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlPipe (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   stallE,
  input  logic                   flushE,
  input  logic                   stallM,
  input  logic                   stallW,
  input  logic                   flushW,
  input  armCtrlPkg::decodeCtrlT ctrlD,
  output armCtrlPkg::decodeCtrlT ctrlE,
  input  armCtrlPkg::memCtrlT    memCtrlE,
  output armCtrlPkg::memCtrlT    memCtrlM,
  input  armCtrlPkg::flagsT      flagsNextE,
  output armCtrlPkg::flagsT      flagsNextM,
  output armCtrlPkg::flagsT      flagsNextW,
  output armCtrlPkg::wbCtrlT     wbCtrlW
);

  armCtrlPkg::wbCtrlT wbCtrlM;

  // Writeback only needs the result-side bits of M
  assign wbCtrlM.memtoReg = memCtrlM.memtoReg;
  assign wbCtrlM.regWrite = memCtrlM.regWrite;
  assign wbCtrlM.pcSrc    = memCtrlM.pcSrc;
  assign wbCtrlM.setFlags = memCtrlM.setFlags;

  // ============================================================
  // Decode to Execute
  // ============================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlE <= '0;
    end else if (flushE) begin
      ctrlE <= '0;            // Bubble wins over stall
    end else if (!stallE) begin
      ctrlE <= ctrlD;
    end
  end

  // ============================================================
  // Execute to Memory
  // ============================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memCtrlM   <= '0;
      flagsNextM <= '0;
    end else if (!stallM) begin   // no flush at this stage
      memCtrlM   <= memCtrlE;
      flagsNextM <= flagsNextE;
    end
  end

  // ============================================================
  // Memory to Writeback
  // ============================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbCtrlW    <= '0;
      flagsNextW <= '0;
    end else if (flushW) begin
      wbCtrlW    <= '0;
      flagsNextW <= '0;
    end else if (!stallW) begin
      wbCtrlW    <= wbCtrlM;
      flagsNextW <= flagsNextM;
    end
  end

endmodule

`default_nettype wire

// ==== logic/statusReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module statusReg (
  input  logic              clk,
  input  logic              rstN,
  input  logic              stallW,
  input  logic              setFlagsM,
  input  logic              setFlagsW,
  input  armCtrlPkg::flagsT flagsNextM,
  input  armCtrlPkg::flagsT flagsNextW,
  output armCtrlPkg::flagsT flagsE,
  output armCtrlPkg::flagsT flags
);

  // Architectural NZCV, written as the setter leaves Writeback
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else if (setFlagsW && !stallW) begin
      flags <= flagsNextW;
    end
  end

  // Youngest pending update wins
  always_comb begin
    if (setFlagsM)
      flagsE = flagsNextM;
    else if (setFlagsW)
      flagsE = flagsNextW;
    else
      flagsE = flags;
  end

endmodule

`default_nettype wire

// ==== logic/armCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module armCtrl (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic [armCtrlPkg::instrWidth-1:0] instrD,
  input  armCtrlPkg::flagsT                 aluFlagsE,
  input  logic [1:0]                        addrLowE,   // from the datapath ALU result
  input  logic                              stallE,
  input  logic                              flushE,
  input  logic                              stallM,
  input  logic                              stallW,
  input  logic                              flushW,
  output logic [1:0]                        regSrcD,
  output logic [1:0]                        immSrcD,
  output logic                              aluSrcE,
  output armCtrlPkg::aluOpE                 aluControlE,
  output logic                              branchTakenE,
  output logic                              memWriteM,
  output logic [3:0]                        byteMaskM,
  output logic                              memtoRegW,
  output logic                              regWriteW,
  output logic                              pcSrcW,
  output logic                              pcWrPendingF,
  output armCtrlPkg::flagsT                 flags
);

  armCtrlPkg::decodeCtrlT ctrlD;
  armCtrlPkg::decodeCtrlT ctrlE;
  armCtrlPkg::memCtrlT    memCtrlE;
  armCtrlPkg::memCtrlT    memCtrlM;
  armCtrlPkg::wbCtrlT     wbCtrlW;
  armCtrlPkg::flagsT      flagsE;
  armCtrlPkg::flagsT      flagsNextE;
  armCtrlPkg::flagsT      flagsNextM;
  armCtrlPkg::flagsT      flagsNextW;

  instrDecoder decoder_i (
    .instrD  (instrD),
    .ctrlD   (ctrlD),
    .regSrcD (regSrcD),
    .immSrcD (immSrcD)
  );

  ctrlPipe pipe_i (
    .clk        (clk),
    .rstN       (rstN),
    .stallE     (stallE),
    .flushE     (flushE),
    .stallM     (stallM),
    .stallW     (stallW),
    .flushW     (flushW),
    .ctrlD      (ctrlD),
    .ctrlE      (ctrlE),
    .memCtrlE   (memCtrlE),
    .memCtrlM   (memCtrlM),
    .flagsNextE (flagsNextE),
    .flagsNextM (flagsNextM),
    .flagsNextW (flagsNextW),
    .wbCtrlW    (wbCtrlW)
  );

  execControl exec_i (
    .ctrlE        (ctrlE),
    .flagsE       (flagsE),
    .aluFlagsE    (aluFlagsE),
    .addrLowE     (addrLowE),
    .memCtrlE     (memCtrlE),
    .flagsNextE   (flagsNextE),
    .branchTakenE (branchTakenE)
  );

  statusReg status_i (
    .clk        (clk),
    .rstN       (rstN),
    .stallW     (stallW),
    .setFlagsM  (memCtrlM.setFlags),
    .setFlagsW  (wbCtrlW.setFlags),
    .flagsNextM (flagsNextM),
    .flagsNextW (flagsNextW),
    .flagsE     (flagsE),
    .flags      (flags)
  );

  assign aluSrcE     = ctrlE.aluSrc;
  assign aluControlE = ctrlE.aluControl;
  assign memWriteM   = memCtrlM.memWrite;
  assign byteMaskM   = memCtrlM.byteMask;
  assign memtoRegW   = wbCtrlW.memtoReg;
  assign regWriteW   = wbCtrlW.regWrite;
  assign pcSrcW      = wbCtrlW.pcSrc;

  // Fetch must hold while any PC write is in flight; E uses the ungated bit
  assign pcWrPendingF = ctrlD.pcSrc | ctrlE.pcSrc | memCtrlM.pcSrc;

endmodule

`default_nettype wire

// ==== testbench/armCtrl_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module armCtrl_checker (
  input  logic                clk,
  input  logic                rstN,
  input  armCtrlPkg::memCtrlT memCtrlM,
  input  logic                memWriteM,
  input  logic [3:0]          byteMaskM,
  input  logic                memtoRegW,
  input  logic                regWriteW,
  input  logic                pcSrcW,
  input  logic                branchTakenE,
  input  logic                aluSrcE,
  input  armCtrlPkg::aluOpE   aluControlE,
  input  logic                pcWrPendingF,
  input  armCtrlPkg::flagsT   flags
);

  // ============================================================
  // Reset state
  // ============================================================
  resetQuiet: assert property (@(negedge clk) !rstN |->
      ({memWriteM, byteMaskM, memtoRegW, regWriteW, pcSrcW, branchTakenE, aluSrcE} == 10'd0
       && aluControlE == armCtrlPkg::aluAnd && flags == 4'd0))
    else $error("Control outputs are not zero while reset is asserted");

  // ============================================================
  // Memory stage rules
  // ============================================================
  maskShape: assert property (@(posedge clk) disable iff (!rstN)
      (memWriteM || memCtrlM.memtoReg) |-> (byteMaskM == 4'b1111 || $onehot(byteMaskM)))
    else $error("Byte mask is neither a full word nor a single lane");

  noLoadStore: assert property (@(posedge clk) disable iff (!rstN)
      !(memWriteM && memCtrlM.memtoReg))
    else $error("Store enable seen together with a load in Memory");

  // A taken branch must hold fetch
  pcPending: assert property (@(posedge clk) disable iff (!rstN)
      branchTakenE |-> pcWrPendingF)
    else $error("Taken branch without a pending PC write");

endmodule

bind armCtrl armCtrl_checker checker_i (
  .clk          (clk),
  .rstN         (rstN),
  .memCtrlM     (memCtrlM),
  .memWriteM    (memWriteM),
  .byteMaskM    (byteMaskM),
  .memtoRegW    (memtoRegW),
  .regWriteW    (regWriteW),
  .pcSrcW       (pcSrcW),
  .branchTakenE (branchTakenE),
  .aluSrcE      (aluSrcE),
  .aluControlE  (aluControlE),
  .pcWrPendingF (pcWrPendingF),
  .flags        (flags)
);

`default_nettype wire

// ==== testbench/armCtrlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module armCtrlTb;

  localparam int numInstr    = 2000;
  localparam int clkPeriod   = 4;
  localparam int resetCycles = 8;
  localparam int watchdogNs  = numInstr * 4 * clkPeriod + resetCycles * clkPeriod;
  localparam logic [31:0] noOpInstr = 32'hec00_0000;   // Bits 27:26 of 11

  logic clk = 1'b0;
  logic rstN;
  logic [31:0] instrD;
  armCtrlPkg::flagsT aluFlagsE;
  logic [1:0] addrLowE;
  logic stallE, flushE, stallM, stallW, flushW;

  logic [1:0] regSrcD, immSrcD;
  logic aluSrcE, branchTakenE, memWriteM, memtoRegW, regWriteW, pcSrcW, pcWrPendingF;
  logic [3:0] byteMaskM;
  armCtrlPkg::aluOpE aluControlE;
  armCtrlPkg::flagsT flags;

  // Reference pipeline state
  armCtrlPkg::decodeCtrlT modelE;
  armCtrlPkg::memCtrlT    modelM;
  armCtrlPkg::wbCtrlT     modelW;
  armCtrlPkg::flagsT      pendM, pendW, archFlags;
  logic [31:0]            seed = 32'hc8c194bc;

  always #(clkPeriod / 2) clk = ~clk;

  armCtrl armCtrl_i (
    .clk (clk), .rstN (rstN), .instrD (instrD), .aluFlagsE (aluFlagsE),
    .addrLowE (addrLowE), .stallE (stallE), .flushE (flushE), .stallM (stallM),
    .stallW (stallW), .flushW (flushW), .regSrcD (regSrcD), .immSrcD (immSrcD),
    .aluSrcE (aluSrcE), .aluControlE (aluControlE), .branchTakenE (branchTakenE),
    .memWriteM (memWriteM), .byteMaskM (byteMaskM), .memtoRegW (memtoRegW),
    .regWriteW (regWriteW), .pcSrcW (pcSrcW), .pcWrPendingF (pcWrPendingF),
    .flags (flags)
  );

  // ============================================================
  // Reference rules
  // ============================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic armCtrlPkg::decodeCtrlT decodeRef(input logic [31:0] instr,
      output logic [1:0] regSrc, output logic [1:0] immSrc);
    armCtrlPkg::decodeCtrlT c;
    logic isDp, isLs, isBr;
    c            = '0;
    c.cond       = armCtrlPkg::condE'(instr[31:28]);
    c.aluControl = armCtrlPkg::aluAdd;
    isDp   = instr[27:26] == 2'b00 && !(!instr[25] && instr[7] && instr[4]);
    isLs   = instr[27:26] == 2'b01 && !(instr[25] && instr[4]);
    isBr   = instr[27:26] == 2'b10;
    immSrc = isBr ? 2'd2 : (isLs ? 2'd1 : 2'd0);
    if (isDp) begin
      c.aluControl = armCtrlPkg::aluOpE'(instr[24:21]);
      c.flagWrite  = instr[20];
      c.aluSrc     = instr[25];
      c.regWrite   = instr[24:23] != 2'b10;   // Opcodes 8 to b only compare
    end else if (isLs) begin
      c.aluControl = instr[23] ? armCtrlPkg::aluAdd : armCtrlPkg::aluSub;
      c.aluSrc     = !instr[25];
      c.byteAccess = instr[22];
      c.memtoReg   = instr[20];
      c.regWrite   = instr[20];
      c.memWrite   = !instr[20];
    end else if (isBr) begin
      c.branch = 1'b1;
      c.aluSrc = 1'b1;
    end
    c.pcSrc = isBr || (c.regWrite && instr[15:12] == 4'hf);
    regSrc  = {c.memWrite, isBr};
    return c;
  endfunction

  // Odd codes invert the even code below them
  function automatic logic condPassRef(input logic [3:0] cond, input armCtrlPkg::flagsT f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c && !f.z;
      3'd5:    base = f.n == f.v;
      3'd6:    base = !f.z && (f.n == f.v);
      default: base = 1'b1;   // AL and NV by inversion
    endcase
    return cond[0] ? !base : base;
  endfunction

  function automatic armCtrlPkg::memCtrlT execRef(input armCtrlPkg::decodeCtrlT c,
      input logic pass, input logic [1:0] addrLow);
    armCtrlPkg::memCtrlT m;
    m.memWrite = c.memWrite && pass;
    m.memtoReg = c.memtoReg;
    m.regWrite = c.regWrite && pass;
    m.pcSrc    = c.pcSrc && pass;
    m.setFlags = c.flagWrite && pass;
    case (addrLow)
      2'd0:    m.byteMask = 4'b0001;
      2'd1:    m.byteMask = 4'b0010;
      2'd2:    m.byteMask = 4'b0100;
      default: m.byteMask = 4'b1000;
    endcase
    if (!c.byteAccess)
      m.byteMask = 4'b1111;
    return m;
  endfunction

  function automatic armCtrlPkg::flagsT forwardFlags();
    if (modelM.setFlags)
      return pendM;
    if (modelW.setFlags)
      return pendW;
    return archFlags;
  endfunction

  function automatic logic [31:0] makeInstr(input logic [31:0] r, input logic [2:0] kind,
      input logic condAl);
    logic [31:0] ins;
    ins = r;
    case (kind)
      3'd0, 3'd1, 3'd2: ins[27:26] = 2'b00;
      3'd3, 3'd4:       ins[27:26] = 2'b01;
      3'd5:             ins[27:26] = 2'b10;
      3'd6:             ins[27:20] = 8'b0011_0101;   // CMP immediate with S
      default: ;                                     // Any encoding
    endcase
    if ((condAl || kind == 3'd6) && kind != 3'd7)
      ins[31:28] = 4'he;
    return ins;
  endfunction

  task automatic expectEq(input string what, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "Output check failed");
    end
  endtask

  // A W stall implies an M stall and an M stall implies an E stall
  task automatic driveRandom();
    logic [31:0] r;
    logic [31:0] s;
    logic w, m;
    seed = xorshift32(seed);
    r    = seed;
    seed = xorshift32(seed);
    s    = seed;
    w    = s[12:10] == 3'd0;
    m    = w || s[15:13] == 3'd0;
    instrD    <= makeInstr(r, s[2:0], s[3]);
    aluFlagsE <= s[7:4];
    addrLowE  <= s[9:8];
    stallW    <= w;
    stallM    <= m;
    stallE    <= m || s[18:16] == 3'd0;
    flushE    <= s[22:19] == 4'd0;
    flushW    <= s[26:23] == 4'd0;
  endtask

  // ============================================================
  // Model update and scoreboard
  // ============================================================
  always @(posedge clk) begin : modelUpdate
    armCtrlPkg::flagsT   fwd;
    armCtrlPkg::memCtrlT nextM;
    logic [1:0] regSrcUnused, immSrcUnused;
    if (!rstN) begin
      modelE    = '0;
      modelM    = '0;
      modelW    = '0;
      pendM     = '0;
      pendW     = '0;
      archFlags = '0;
    end else begin
      fwd   = forwardFlags();
      nextM = execRef(modelE, condPassRef(modelE.cond, fwd), addrLowE);
      if (modelW.setFlags && !stallW)
        archFlags = pendW;
      if (flushW) begin
        modelW = '0;
        pendW  = '0;
      end else if (!stallW) begin
        modelW.memtoReg = modelM.memtoReg;
        modelW.regWrite = modelM.regWrite;
        modelW.pcSrc    = modelM.pcSrc;
        modelW.setFlags = modelM.setFlags;
        pendW           = pendM;
      end
      if (!stallM) begin
        modelM = nextM;
        pendM  = nextM.setFlags ? aluFlagsE : fwd;
      end
      if (flushE)
        modelE = '0;
      else if (!stallE)
        modelE = decodeRef(instrD, regSrcUnused, immSrcUnused);
    end
  end

  always @(negedge clk) begin : scoreboard
    armCtrlPkg::decodeCtrlT decD;
    logic [1:0] regSrcExp, immSrcExp;
    logic takenExp;
    decD     = decodeRef(instrD, regSrcExp, immSrcExp);
    takenExp = modelE.branch && condPassRef(modelE.cond, forwardFlags());
    expectEq("regSrcD", {6'd0, regSrcD}, {6'd0, regSrcExp});
    expectEq("immSrcD", {6'd0, immSrcD}, {6'd0, immSrcExp});
    expectEq("aluSrcE", {7'd0, aluSrcE}, {7'd0, modelE.aluSrc});
    expectEq("aluControlE", {4'd0, aluControlE}, {4'd0, modelE.aluControl});
    expectEq("branchTakenE", {7'd0, branchTakenE}, {7'd0, takenExp});
    expectEq("memWriteM", {7'd0, memWriteM}, {7'd0, modelM.memWrite});
    expectEq("byteMaskM", {4'd0, byteMaskM}, {4'd0, modelM.byteMask});
    expectEq("memtoRegW", {7'd0, memtoRegW}, {7'd0, modelW.memtoReg});
    expectEq("regWriteW", {7'd0, regWriteW}, {7'd0, modelW.regWrite});
    expectEq("pcSrcW", {7'd0, pcSrcW}, {7'd0, modelW.pcSrc});
    expectEq("pcWrPendingF", {7'd0, pcWrPendingF},
             {7'd0, decD.pcSrc || modelE.pcSrc || modelM.pcSrc});
    expectEq("flags", {4'd0, flags}, {4'd0, archFlags});
  end

  // ============================================================
  // Stimulus and watchdog
  // ============================================================
  initial begin : stimulus
    rstN      = 1'b0;
    instrD    = noOpInstr;
    aluFlagsE = '0;
    addrLowE  = 2'd0;
    stallE    = 1'b0;
    flushE    = 1'b0;
    stallM    = 1'b0;
    stallW    = 1'b0;
    flushW    = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
    for (int i = 0; i < numInstr; i++) begin
      @(posedge clk);
      driveRandom();
    end
    @(posedge clk);
    instrD <= noOpInstr;   // Drain with bubbles
    stallE <= 1'b0;
    flushE <= 1'b0;
    stallM <= 1'b0;
    stallW <= 1'b0;
    flushW <= 1'b0;
    repeat (4) @(posedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin : watchdog
    #(watchdogNs);
    $display("Timeout: the run did not finish within %0d ns", watchdogNs);
    $display("TESTBENCH FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// ==== armCtrl.f ====
logic/armCtrlPkg.sv
logic/instrDecoder.sv
logic/execControl.sv
logic/ctrlPipe.sv
logic/statusReg.sv
logic/armCtrl.sv
testbench/armCtrl_checker.sv
testbench/armCtrlTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the armCtrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

if ! verilator --binary --timing --assert -j 0 \
    --top-module armCtrlTb -Mdir "$buildDir" -f armCtrl.f; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/VarmCtrlTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "TESTBENCH FAILED" "$logFile"; then
  exit 1
fi

if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

exit 0
